//--- verilog/rx_concentrator_defines.svh
`ifndef RX_CONCENTRATOR_DEFINES_SVH
`define RX_CONCENTRATOR_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Concentrator sizing
//////////////////////////////////////////////////////////////////////

// Serial lines, one receive slot each
`define RX_SLOTS 4

// Oversampling ratio of the receivers
`define RX_CLOCKS_PER_BIT 16

// Words buffered per slot
`define SLOT_BUFFER_DEPTH 4

// Shared FIFO entries
`define RX_FIFO_DEPTH 16

`endif

//--- verilog/rx_concentrator_pkg.sv
`include "rx_concentrator_defines.svh"

package rx_concentrator_pkg;

// Nine data bits, bit 8 is the multidrop address mark
typedef logic [8:0] rx_word_t;

typedef logic [$clog2(`RX_SLOTS)-1:0] slot_index_t;

// One bit wider than the pointer so a full FIFO is representable
typedef logic [$clog2(`RX_FIFO_DEPTH + 1)-1:0] fifo_count_t;

typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
} receiver_state_t;

typedef enum logic {
    ARB_IDLE,
    ARB_PASSTHROUGH
} arbiter_state_t;

endpackage

//--- verilog/serial_word_receiver.sv
`include "rx_concentrator_defines.svh"

module serial_word_receiver (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          rx,
    output rx_concentrator_pkg::rx_word_t word,
    output logic                          word_valid,
    output logic                          frame_error
);

localparam int COUNT_WIDTH = $clog2(`RX_CLOCKS_PER_BIT);
// Sync chain delay taken off the half-bit wait
localparam logic [COUNT_WIDTH-1:0] HALF_BIT_LAST = COUNT_WIDTH'(`RX_CLOCKS_PER_BIT / 2 - 2);
localparam logic [COUNT_WIDTH-1:0] FULL_BIT_LAST = COUNT_WIDTH'(`RX_CLOCKS_PER_BIT - 1);

rx_concentrator_pkg::receiver_state_t state;
rx_concentrator_pkg::receiver_state_t _state;
logic   [1:0]                         rx_sync;
logic                                 rx_prev;
logic                                 rx_line;
logic   [COUNT_WIDTH-1:0]             bit_clock_count;
logic   [COUNT_WIDTH-1:0]             _bit_clock_count;
logic   [3:0]                         bit_index;
logic   [3:0]                         _bit_index;
rx_concentrator_pkg::rx_word_t        shift;
rx_concentrator_pkg::rx_word_t        _shift;
logic                                 _word_valid;
logic                                 _frame_error;

assign rx_line = rx_sync[1];
assign word    = shift;

//////////////////////////////////////////////////////////////////////
// Frame state machine
//////////////////////////////////////////////////////////////////////
always_comb begin
    _state           = state;
    _bit_clock_count = bit_clock_count + 1'b1;
    _bit_index       = bit_index;
    _shift           = shift;
    _word_valid      = 1'b0;
    _frame_error     = 1'b0;

    case (state)
        rx_concentrator_pkg::RX_IDLE: begin
            _bit_clock_count = '0;
            // Falling edge marks the start bit
            if (rx_prev && !rx_line) begin
                _state = rx_concentrator_pkg::RX_START;
            end
        end
        rx_concentrator_pkg::RX_START: begin
            if (bit_clock_count == HALF_BIT_LAST) begin
                _bit_clock_count = '0;
                _bit_index       = '0;
                // Glitch rejection, start bit must still be low
                if (!rx_line) begin
                    _state = rx_concentrator_pkg::RX_DATA;
                end
                else begin
                    _state = rx_concentrator_pkg::RX_IDLE;
                end
            end
        end
        rx_concentrator_pkg::RX_DATA: begin
            if (bit_clock_count == FULL_BIT_LAST) begin
                _bit_clock_count = '0;
                // LSB first, so shift in from the top
                _shift = {rx_line, shift[8:1]};
                if (bit_index == 4'd8) begin
                    _state = rx_concentrator_pkg::RX_STOP;
                end
                else begin
                    _bit_index = bit_index + 1'b1;
                end
            end
        end
        rx_concentrator_pkg::RX_STOP: begin
            if (bit_clock_count == FULL_BIT_LAST) begin
                _state = rx_concentrator_pkg::RX_IDLE;
                if (rx_line) begin
                    _word_valid = 1'b1;
                end
                else begin
                    _frame_error = 1'b1;
                end
            end
        end
        default: begin
            _state = rx_concentrator_pkg::RX_IDLE;
        end
    endcase
end

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        rx_sync         <= 2'b11;
        rx_prev         <= 1'b1;
        state           <= rx_concentrator_pkg::RX_IDLE;
        bit_clock_count <= '0;
        bit_index       <= '0;
        word_valid      <= 1'b0;
        frame_error     <= 1'b0;
    end
    else begin
        rx_sync         <= {rx_sync[0], rx};
        rx_prev         <= rx_line;
        state           <= _state;
        bit_clock_count <= _bit_clock_count;
        bit_index       <= _bit_index;
        word_valid      <= _word_valid;
        frame_error     <= _frame_error;
    end
end

always_ff @(posedge clock) begin
    shift <= _shift;
end

endmodule

//--- verilog/receive_slot.sv
`include "rx_concentrator_defines.svh"

module receive_slot (
    input  logic                          clock,
    input  logic                          reset_n,
    input  rx_concentrator_pkg::rx_word_t word,
    input  logic                          word_valid,
    input  logic                          ready,
    output logic                          enable,
    output rx_concentrator_pkg::rx_word_t data,
    output logic                          data_enable
);

localparam int PTR_WIDTH   = $clog2(`SLOT_BUFFER_DEPTH);
localparam int COUNT_WIDTH = $clog2(`SLOT_BUFFER_DEPTH + 1);
localparam logic [COUNT_WIDTH-1:0] DEPTH = COUNT_WIDTH'(`SLOT_BUFFER_DEPTH);

rx_concentrator_pkg::rx_word_t buffer [`SLOT_BUFFER_DEPTH];
logic   [PTR_WIDTH-1:0]        write_ptr;
logic   [PTR_WIDTH-1:0]        read_ptr;
logic   [COUNT_WIDTH-1:0]      count;
logic                          push;
logic                          pop;

// Pop only while enable is still up, so the arbiter copies every word
assign pop  = ready && enable && (count != '0);
// New word is dropped when the buffer is full
assign push = word_valid && ((count != DEPTH) || pop);

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        write_ptr   <= '0;
        read_ptr    <= '0;
        count       <= '0;
        enable      <= 1'b0;
        data_enable <= 1'b0;
    end
    else begin
        if (push) begin
            write_ptr <= write_ptr + 1'b1;
        end
        if (pop) begin
            read_ptr <= read_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
        // Not-empty level, lagging one cycle to cover the last word
        enable      <= (count != '0);
        data_enable <= pop;
    end
end

always_ff @(posedge clock) begin
    if (push) begin
        buffer[write_ptr] <= word;
    end
    if (pop) begin
        data <= buffer[read_ptr];
    end
end

endmodule

//--- verilog/receive_slot_arbiter.sv
`include "rx_concentrator_defines.svh"

module receive_slot_arbiter (
    input  logic                                          clock,
    input  logic                                          reset_n,
    input  logic [`RX_SLOTS-1:0]                          enable,
    input  rx_concentrator_pkg::rx_word_t [`RX_SLOTS-1:0] data,
    input  logic [`RX_SLOTS-1:0]                          data_enable,
    output logic [`RX_SLOTS-1:0]                          ready,
    output rx_concentrator_pkg::rx_word_t                 push_data,
    output rx_concentrator_pkg::slot_index_t              push_slot,
    output logic                                          push_data_valid
);

localparam rx_concentrator_pkg::slot_index_t SLOT_LAST =
    rx_concentrator_pkg::slot_index_t'(`RX_SLOTS - 1);

rx_concentrator_pkg::arbiter_state_t state;
rx_concentrator_pkg::arbiter_state_t _state;
rx_concentrator_pkg::slot_index_t    slot_select;
rx_concentrator_pkg::slot_index_t    _slot_select;
rx_concentrator_pkg::slot_index_t    next_slot;
logic   [`RX_SLOTS-1:0]              _ready;
logic                                _push_data_valid;

// Round-robin pointer, wraps to slot 0
assign next_slot = (slot_select == SLOT_LAST) ? '0 : slot_select + 1'b1;

always_comb begin
    _state           = state;
    _ready           = ready;
    _slot_select     = slot_select;
    _push_data_valid = 1'b0;

    case (state)
        rx_concentrator_pkg::ARB_IDLE: begin
            if (enable[slot_select]) begin
                _state              = rx_concentrator_pkg::ARB_PASSTHROUGH;
                _ready              = '0;
                _ready[slot_select] = 1'b1;
            end
            else begin
                _slot_select = next_slot;
            end
        end
        rx_concentrator_pkg::ARB_PASSTHROUGH: begin
            if (!enable[slot_select]) begin
                _state       = rx_concentrator_pkg::ARB_IDLE;
                _ready       = '0;
                _slot_select = next_slot;
            end
            else begin
                _push_data_valid = data_enable[slot_select];
            end
        end
        default: begin
            _state = rx_concentrator_pkg::ARB_IDLE;
            _ready = '0;
        end
    endcase
end

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        state           <= rx_concentrator_pkg::ARB_IDLE;
        ready           <= '0;
        slot_select     <= '0;
        push_data_valid <= 1'b0;
    end
    else begin
        state           <= _state;
        ready           <= _ready;
        slot_select     <= _slot_select;
        push_data_valid <= _push_data_valid;
    end
end

// Word and its source slot, loaded with the strobe
always_ff @(posedge clock) begin
    if (_push_data_valid) begin
        push_data <= data[slot_select];
        push_slot <= slot_select;
    end
end

endmodule

//--- verilog/receive_fifo.sv
`include "rx_concentrator_defines.svh"

module receive_fifo (
    input  logic                             clock,
    input  logic                             reset_n,
    input  rx_concentrator_pkg::rx_word_t    push_data,
    input  rx_concentrator_pkg::slot_index_t push_slot,
    input  logic                             push_data_valid,
    input  logic                             read_strobe,
    output rx_concentrator_pkg::rx_word_t    read_data,
    output rx_concentrator_pkg::slot_index_t read_slot,
    output logic                             read_valid,
    output logic                             overflow
);

localparam int PTR_WIDTH = $clog2(`RX_FIFO_DEPTH);
localparam rx_concentrator_pkg::fifo_count_t DEPTH =
    rx_concentrator_pkg::fifo_count_t'(`RX_FIFO_DEPTH);

rx_concentrator_pkg::rx_word_t    data_mem [`RX_FIFO_DEPTH];
rx_concentrator_pkg::slot_index_t slot_mem [`RX_FIFO_DEPTH];
logic   [PTR_WIDTH-1:0]           write_ptr;
logic   [PTR_WIDTH-1:0]           read_ptr;
rx_concentrator_pkg::fifo_count_t count;
logic                             full;
logic                             push;
logic                             pop;

assign full = (count == DEPTH);
assign push = push_data_valid && !full;
assign pop  = read_strobe && (count != '0);

// Head entry shows ahead
assign read_valid = (count != '0);
assign read_data  = data_mem[read_ptr];
assign read_slot  = slot_mem[read_ptr];

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        write_ptr <= '0;
        read_ptr  <= '0;
        count     <= '0;
        overflow  <= 1'b0;
    end
    else begin
        if (push) begin
            write_ptr <= write_ptr + 1'b1;
        end
        if (pop) begin
            read_ptr <= read_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
        // Sticky until reset
        if (push_data_valid && full) begin
            overflow <= 1'b1;
        end
    end
end

always_ff @(posedge clock) begin
    if (push) begin
        data_mem[write_ptr] <= push_data;
        slot_mem[write_ptr] <= push_slot;
    end
end

endmodule

//--- verilog/rx_concentrator.sv
`include "rx_concentrator_defines.svh"

module rx_concentrator (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic [`RX_SLOTS-1:0]             rx,
    input  logic                             read_strobe,
    output rx_concentrator_pkg::rx_word_t    read_data,
    output rx_concentrator_pkg::slot_index_t read_slot,
    output logic                             read_valid,
    output logic                             overflow,
    output logic [`RX_SLOTS-1:0]             frame_error
);

rx_concentrator_pkg::rx_word_t [`RX_SLOTS-1:0] line_word;
rx_concentrator_pkg::rx_word_t [`RX_SLOTS-1:0] slot_data;
logic   [`RX_SLOTS-1:0]                        line_word_valid;
logic   [`RX_SLOTS-1:0]                        line_frame_error;
logic   [`RX_SLOTS-1:0]                        slot_enable;
logic   [`RX_SLOTS-1:0]                        slot_data_enable;
logic   [`RX_SLOTS-1:0]                        slot_ready;
rx_concentrator_pkg::rx_word_t                 push_data;
rx_concentrator_pkg::slot_index_t              push_slot;
logic                                          push_data_valid;

//////////////////////////////////////////////////////////////////////
// Per-line receiver and slot buffer
//////////////////////////////////////////////////////////////////////
for (genvar i = 0; i < `RX_SLOTS; i++) begin : g_line
    serial_word_receiver i_receiver (
        .clock       (clock),
        .reset_n     (reset_n),
        .rx          (rx[i]),
        .word        (line_word[i]),
        .word_valid  (line_word_valid[i]),
        .frame_error (line_frame_error[i])
    );

    receive_slot i_slot (
        .clock       (clock),
        .reset_n     (reset_n),
        .word        (line_word[i]),
        .word_valid  (line_word_valid[i]),
        .ready       (slot_ready[i]),
        .enable      (slot_enable[i]),
        .data        (slot_data[i]),
        .data_enable (slot_data_enable[i])
    );
end

//////////////////////////////////////////////////////////////////////
// Shared path to the host
//////////////////////////////////////////////////////////////////////
receive_slot_arbiter i_arbiter (
    .clock           (clock),
    .reset_n         (reset_n),
    .enable          (slot_enable),
    .data            (slot_data),
    .data_enable     (slot_data_enable),
    .ready           (slot_ready),
    .push_data       (push_data),
    .push_slot       (push_slot),
    .push_data_valid (push_data_valid)
);

receive_fifo i_fifo (
    .clock           (clock),
    .reset_n         (reset_n),
    .push_data       (push_data),
    .push_slot       (push_slot),
    .push_data_valid (push_data_valid),
    .read_strobe     (read_strobe),
    .read_data       (read_data),
    .read_slot       (read_slot),
    .read_valid      (read_valid),
    .overflow        (overflow)
);

// Framing errors held per line until reset
always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        frame_error <= '0;
    end
    else begin
        frame_error <= frame_error | line_frame_error;
    end
end

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int CLOCK_PERIOD_NS = 8,
    parameter int RESET_CYCLES    = 16
) (
    output logic clock,
    output logic reset_n
);

timeunit 1ns;
timeprecision 100ps;

initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD_NS / 2) clock = ~clock;
end

// Reset released just after a rising edge
initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset_n = 1'b1;
end

endmodule

//--- sim/rx_concentrator_asserts.sv
`include "rx_concentrator_defines.svh"

module rx_concentrator_asserts (
    input logic                                clock,
    input logic                                reset_n,
    input logic [`RX_SLOTS-1:0]                enable,
    input logic [`RX_SLOTS-1:0]                ready,
    input logic                                push_data_valid,
    input rx_concentrator_pkg::arbiter_state_t state
);

timeunit 1ns;
timeprecision 100ps;

// Failure counts, read by the testbench at the end of the run
int ready_failures = 0;
int push_failures  = 0;
int drop_failures  = 0;

ready_one_hot: assert property (@(posedge clock) disable iff (!reset_n) $onehot0(ready))
else begin
    ready_failures++;
    $error("ready grants more than one slot");
end

// Words only leave the arbiter while a slot is granted
push_in_passthrough: assert property (@(posedge clock) disable iff (!reset_n)
    push_data_valid |-> (state == rx_concentrator_pkg::ARB_PASSTHROUGH))
else begin
    push_failures++;
    $error("push_data_valid outside the passthrough state");
end

ready_follows_enable: assert property (@(posedge clock) disable iff (!reset_n)
    (|(ready & ~enable)) |=> (ready == '0))
else begin
    drop_failures++;
    $error("ready still high one cycle after the granted enable fell");
end

endmodule

//--- sim/tb_rx_concentrator.sv
`include "rx_concentrator_defines.svh"

module tb_rx_concentrator;

timeunit 1ns;
timeprecision 100ps;

localparam int CLOCK_PERIOD_NS = 8;
// Start, nine data bits, stop and one idle bit
localparam int FRAME_BITS      = 12;
localparam int FRAME_CYCLES    = FRAME_BITS * `RX_CLOCKS_PER_BIT;
localparam int READ_TIMEOUT    = 2 * FRAME_CYCLES;
// Stop bit to FIFO is a few tens of cycles at most
localparam int DRAIN_CYCLES    = 64;
// Frames of tests 2 to 5, test 4 counts its quiet frame
localparam int TEST_FRAMES     = 8 + 5 + 3 + 20;
localparam int WATCHDOG_NS     = 2 * TEST_FRAMES * FRAME_CYCLES * CLOCK_PERIOD_NS;

logic                             clock;
logic                             reset_n;
logic [`RX_SLOTS-1:0]             rx;
logic                             read_strobe;
rx_concentrator_pkg::rx_word_t    read_data;
rx_concentrator_pkg::slot_index_t read_slot;
logic                             read_valid;
logic                             overflow;
logic [`RX_SLOTS-1:0]             frame_error;
int                               seed = 80392;

tb_clock_gen #(
    .CLOCK_PERIOD_NS (CLOCK_PERIOD_NS),
    .RESET_CYCLES    (16)
) i_clock_gen (
    .clock   (clock),
    .reset_n (reset_n)
);

rx_concentrator i_dut (
    .clock       (clock),
    .reset_n     (reset_n),
    .rx          (rx),
    .read_strobe (read_strobe),
    .read_data   (read_data),
    .read_slot   (read_slot),
    .read_valid  (read_valid),
    .overflow    (overflow),
    .frame_error (frame_error)
);

bind receive_slot_arbiter rx_concentrator_asserts i_arbiter_asserts (
    .clock           (clock),
    .reset_n         (reset_n),
    .enable          (enable),
    .ready           (ready),
    .push_data_valid (push_data_valid),
    .state           (state)
);

//////////////////////////////////////////////////////////////////////
// Reporting and checks
//////////////////////////////////////////////////////////////////////
task automatic report_failure(input string text);
    $display("%s", text);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_value(input string test_name, input string what,
                           input int expected, input int actual);
    assert (actual == expected)
    else report_failure($sformatf("Fail %s: %s expected 0x%0h, actual 0x%0h",
                                  test_name, what, expected, actual));
endtask

function automatic int assertion_failures();
    return i_dut.i_arbiter.i_arbiter_asserts.ready_failures
         + i_dut.i_arbiter.i_arbiter_asserts.push_failures
         + i_dut.i_arbiter.i_arbiter_asserts.drop_failures;
endfunction

//////////////////////////////////////////////////////////////////////
// Serial line and host side drivers
//////////////////////////////////////////////////////////////////////
task automatic send_frame(input rx_concentrator_pkg::slot_index_t line,
                          input rx_concentrator_pkg::rx_word_t word, input logic stop_bit);
    logic [FRAME_BITS-1:0] bits;
    // LSB goes out first
    bits = {1'b1, stop_bit, word, 1'b0};
    @(posedge clock);
    #1;
    repeat (FRAME_BITS) begin
        rx[line] = bits[0];
        bits     = bits >> 1;
        repeat (`RX_CLOCKS_PER_BIT) @(posedge clock);
        #1;
    end
endtask

task automatic send_words(input rx_concentrator_pkg::slot_index_t line,
                          input rx_concentrator_pkg::rx_word_t words[$]);
    foreach (words[k]) begin
        send_frame(line, words[k], 1'b1);
    end
endtask

// Called just after a rising edge, returns just after one
task automatic read_entry(input string test_name, output rx_concentrator_pkg::rx_word_t word,
                          output rx_concentrator_pkg::slot_index_t slot);
    int waited;
    waited = 0;
    while (!read_valid) begin
        @(posedge clock);
        #1;
        waited++;
        if (waited > READ_TIMEOUT) begin
            report_failure($sformatf("%s: no FIFO entry appeared within %0d cycles",
                                     test_name, READ_TIMEOUT));
        end
    end
    word        = read_data;
    slot        = read_slot;
    read_strobe = 1'b1;
    @(posedge clock);
    #1;
    read_strobe = 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////
task automatic test_reset();
    check_value("reset", "read_valid", 0, int'(read_valid));
    check_value("reset", "overflow", 0, int'(overflow));
    check_value("reset", "frame_error", 0, int'(frame_error));
endtask

task automatic test_single_line();
    rx_concentrator_pkg::rx_word_t    expected[$];
    rx_concentrator_pkg::rx_word_t    word;
    rx_concentrator_pkg::slot_index_t slot;
    for (int i = 0; i < 8; i++) begin
        word    = rx_concentrator_pkg::rx_word_t'($random(seed));
        // Address mark alternates
        word[8] = i[0];
        expected.push_back(word);
        send_frame(rx_concentrator_pkg::slot_index_t'(2), word, 1'b1);
    end
    while (expected.size() != 0) begin
        read_entry("single_line", word, slot);
        check_value("single_line", "read_data", int'(expected.pop_front()), int'(word));
        check_value("single_line", "read_slot", 2, int'(slot));
    end
endtask

task automatic test_all_lines();
    rx_concentrator_pkg::rx_word_t    expected [`RX_SLOTS][$];
    rx_concentrator_pkg::rx_word_t    word;
    rx_concentrator_pkg::slot_index_t slot;
    for (int s = 0; s < `RX_SLOTS; s++) begin
        for (int k = 0; k < 5; k++) begin
            word = rx_concentrator_pkg::rx_word_t'($random(seed));
            expected[rx_concentrator_pkg::slot_index_t'(s)].push_back(word);
        end
    end
    fork
        send_words(rx_concentrator_pkg::slot_index_t'(0),
                   expected[rx_concentrator_pkg::slot_index_t'(0)]);
        send_words(rx_concentrator_pkg::slot_index_t'(1),
                   expected[rx_concentrator_pkg::slot_index_t'(1)]);
        send_words(rx_concentrator_pkg::slot_index_t'(2),
                   expected[rx_concentrator_pkg::slot_index_t'(2)]);
        send_words(rx_concentrator_pkg::slot_index_t'(3),
                   expected[rx_concentrator_pkg::slot_index_t'(3)]);
        // Host drains while the lines are busy
        repeat (`RX_SLOTS * 5) begin
            read_entry("all_lines", word, slot);
            assert (expected[slot].size() != 0)
            else report_failure($sformatf("all_lines: extra word 0x%0h from slot %0d",
                                          word, slot));
            check_value("all_lines", "read_data", int'(expected[slot].pop_front()),
                        int'(word));
        end
    join
    check_value("all_lines", "read_valid", 0, int'(read_valid));
    check_value("all_lines", "overflow", 0, int'(overflow));
endtask

task automatic test_frame_error();
    rx_concentrator_pkg::rx_word_t    bad_word;
    rx_concentrator_pkg::rx_word_t    good_word;
    rx_concentrator_pkg::rx_word_t    word;
    rx_concentrator_pkg::slot_index_t slot;
    bad_word  = rx_concentrator_pkg::rx_word_t'($random(seed));
    good_word = rx_concentrator_pkg::rx_word_t'($random(seed));
    send_frame(rx_concentrator_pkg::slot_index_t'(1), bad_word, 1'b0);
    send_frame(rx_concentrator_pkg::slot_index_t'(1), good_word, 1'b1);
    read_entry("frame_error", word, slot);
    check_value("frame_error", "read_data", int'(good_word), int'(word));
    check_value("frame_error", "read_slot", 1, int'(slot));
    // Nothing else may arrive
    repeat (FRAME_CYCLES) @(posedge clock);
    #1;
    check_value("frame_error", "read_valid", 0, int'(read_valid));
    check_value("frame_error", "frame_error", 2, int'(frame_error));
endtask

task automatic test_overflow();
    rx_concentrator_pkg::rx_word_t    words[$];
    rx_concentrator_pkg::rx_word_t    word;
    rx_concentrator_pkg::slot_index_t slot;
    repeat (20) begin
        words.push_back(rx_concentrator_pkg::rx_word_t'($random(seed)));
    end
    send_words(rx_concentrator_pkg::slot_index_t'(0), words);
    repeat (DRAIN_CYCLES) @(posedge clock);
    #1;
    check_value("overflow", "overflow", 1, int'(overflow));
    repeat (`RX_FIFO_DEPTH) begin
        read_entry("overflow", word, slot);
        check_value("overflow", "read_data", int'(words.pop_front()), int'(word));
        check_value("overflow", "read_slot", 0, int'(slot));
    end
    check_value("overflow", "read_valid", 0, int'(read_valid));
    check_value("overflow", "overflow", 1, int'(overflow));
endtask

//////////////////////////////////////////////////////////////////////
// Test sequence and watchdog
//////////////////////////////////////////////////////////////////////
initial begin
    rx          = '1;
    read_strobe = 1'b0;
    @(posedge reset_n);
    @(posedge clock);
    #1;
    test_reset();
    test_single_line();
    test_all_lines();
    test_frame_error();
    test_overflow();
    if (assertion_failures() == 0) begin
        $display("** PASS **");
        $finish;
    end
    else begin
        report_failure($sformatf("Arbiter assertions failed %0d times", assertion_failures()));
    end
end

initial begin
    #(WATCHDOG_NS);
    report_failure($sformatf("Watchdog expired after %0d ns, the tests did not finish",
                             WATCHDOG_NS));
end

endmodule

//--- filelist.f
+incdir+verilog
verilog/rx_concentrator_pkg.sv
verilog/serial_word_receiver.sv
verilog/receive_slot.sv
verilog/receive_slot_arbiter.sv
verilog/receive_fifo.sv
verilog/rx_concentrator.sv
sim/tb_clock_gen.sv
sim/rx_concentrator_asserts.sv
sim/tb_rx_concentrator.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_rx_concentrator
FILELIST  := filelist.f
BUILD_DIR := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf $(BUILD_DIR)
